// File: hdl/cache_pkg.sv
package cache_pkg;

    // fetch address split: | tag | index | word | byte |
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 5;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;   // 23

    localparam int LINE_WORDS = 4;
    localparam int WORD_W     = $clog2(LINE_WORDS);          // word select within a line

    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 2 ** INDEX_W;

    // core -> cache
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;   // byte address
    } fetch_req_t;

    // cache -> core, valid is a single cycle pulse
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } fetch_rsp_t;

    // S_ALLOCATE covers the l2 request and the beat collection
    typedef enum logic [1:0] {
        S_IDLE     = 2'b00,
        S_COMPARE  = 2'b01,
        S_ALLOCATE = 2'b11
    } ctrl_state_e;

endpackage

// File: hdl/l2_pkg.sv
package l2_pkg;

    // line address is tag and index, no offset
    localparam int L2_ADDR_W = 28;
    localparam int L2_DATA_W = 32;

    // line fetch request, no back-pressure
    typedef struct packed {
        logic                 valid;
        logic [L2_ADDR_W-1:0] line_addr;
    } l2_req_t;

    // one word of a refill line
    typedef struct packed {
        logic                 valid;
        logic [L2_DATA_W-1:0] data;
        logic                 last;   // final beat of the line
    } refill_beat_t;

endpackage

// File: hdl/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl
    import cache_pkg::*;
    import l2_pkg::*;
(
    input  logic               clk,
    input  logic               nrst,
    input  fetch_req_t         fetch_req,
    input  logic               flush,
    output logic               stall,
    output logic               fetch_rsp_valid,
    output l2_req_t            l2_req,
    input  refill_beat_t       beat_out,
    input  logic               beat_avail,
    output logic               beat_pop,
    output logic               rd_way,
    output logic [INDEX_W-1:0] rd_index,
    output logic [WORD_W-1:0]  rd_word,
    output logic               wr_en,
    output logic               wr_way,
    output logic [INDEX_W-1:0] wr_index,
    output logic [WORD_W-1:0]  wr_word,
    output logic [31:0]        wr_data
);

    ctrl_state_e state, next_state;

    logic [ADDR_W-1:0] addr_q;
    logic [TAG_W-1:0]  tag_arr [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0] lru_q;   // way to replace next

    logic hit_q;                  // lookup hit, second compare cycle
    logic way_q;                  // way in use for this request
    logic l2_req_valid_q;
    logic [WORD_W-1:0] word_cnt;

    logic [TAG_W-1:0]    req_tag;
    logic [INDEX_W-1:0]  req_index;
    logic [WORD_W-1:0]   req_word;
    logic [NUM_WAYS-1:0] way_match;
    logic lookup_hit;
    logic hit_way;
    logic pick_way;
    logic accept;
    logic refill_done;

    assign req_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign req_index = addr_q[OFFSET_W +: INDEX_W];
    assign req_word  = addr_q[OFFSET_W-1 -: WORD_W];

    assign stall       = (state != S_IDLE);
    assign accept      = (state == S_IDLE) && fetch_req.valid;
    assign beat_pop    = (state == S_ALLOCATE) && beat_avail;
    assign refill_done = beat_pop && beat_out.last;

    // tag compare for both ways of the set
    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_match[w] = valid_q[req_index][w] && (tag_arr[w][req_index] == req_tag);
        end
    end

    assign lookup_hit = |way_match;
    assign hit_way    = !way_match[0];

    // matching way, then first invalid way, then lru
    always_comb
    begin
        if (lookup_hit)
            pick_way = hit_way;
        else if (!valid_q[req_index][0])
            pick_way = 1'b0;
        else if (!valid_q[req_index][1])
            pick_way = 1'b1;
        else
            pick_way = lru_q[req_index];
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
                if (accept)
                    next_state = S_COMPARE;
            S_COMPARE:
                if (hit_q)
                    next_state = S_IDLE;
                else if (!lookup_hit)
                    next_state = S_ALLOCATE;
            S_ALLOCATE:
                if (refill_done)
                    next_state = S_COMPARE;   // replay the lookup, it hits now
            default:
                next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state           <= S_IDLE;
            hit_q           <= 1'b0;
            way_q           <= 1'b0;
            fetch_rsp_valid <= 1'b0;
            l2_req_valid_q  <= 1'b0;
        end
        else
        begin
            state           <= next_state;
            hit_q           <= (state == S_COMPARE) && lookup_hit && !hit_q;
            fetch_rsp_valid <= (state == S_COMPARE) && hit_q;
            l2_req_valid_q  <= (state == S_COMPARE) && !lookup_hit && !hit_q;
            if ((state == S_COMPARE) && !hit_q)
                way_q <= pick_way;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= fetch_req.addr;
    end

    // flush only when idle, before the lookup of a request taken on the same edge
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid_q <= '0;
        else if ((state == S_IDLE) && flush)
            valid_q <= '0;
        else if (refill_done)
            valid_q[req_index][way_q] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (refill_done)
            tag_arr[way_q][req_index] <= req_tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru_q <= '0;
        else if ((state == S_COMPARE) && lookup_hit && !hit_q)
            lru_q[req_index] <= !hit_way;   // point at the other way
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            word_cnt <= '0;
        else if (beat_pop)
            word_cnt <= refill_done ? '0 : word_cnt + 1'b1;
    end

    assign l2_req = '{valid: l2_req_valid_q, line_addr: addr_q[ADDR_W-1:OFFSET_W]};

    // read port held on the request, data lands one cycle later
    assign rd_way   = way_q;
    assign rd_index = req_index;
    assign rd_word  = req_word;

    assign wr_en    = beat_pop;
    assign wr_way   = way_q;
    assign wr_index = req_index;
    assign wr_word  = word_cnt;
    assign wr_data  = beat_out.data;

endmodule

// File: hdl/icache_data_array.sv
`timescale 1ns/10ps

module icache_data_array
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               nrst,
    input  logic               rd_way,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic [WORD_W-1:0]  rd_word,
    output logic [31:0]        read_data,
    input  logic               wr_en,
    input  logic               wr_way,
    input  logic [INDEX_W-1:0] wr_index,
    input  logic [WORD_W-1:0]  wr_word,
    input  logic [31:0]        wr_data
);

    localparam int DEPTH  = NUM_WAYS * NUM_SETS * LINE_WORDS;
    localparam int AWIDTH = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AWIDTH-1:0] rd_addr;
    logic [AWIDTH-1:0] wr_addr;

    // flat word address {way, set, word}
    assign rd_addr = {rd_way, rd_index, rd_word};
    assign wr_addr = {wr_way, wr_index, wr_word};

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read, one cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            read_data <= '0;
        else
            read_data <= mem[rd_addr];
    end

endmodule

// File: hdl/refill_buffer.sv
`timescale 1ns/10ps

module refill_buffer
    import l2_pkg::*;
#(
    parameter int REFILL_DEPTH = 4
)
(
    input  logic         clk,
    input  logic         nrst,
    input  refill_beat_t refill_in,
    output refill_beat_t beat_out,
    output logic         beat_avail,
    input  logic         beat_pop,
    output logic         credit_return
);

    localparam int PTR_W = (REFILL_DEPTH > 1) ? $clog2(REFILL_DEPTH) : 1;
    localparam int CNT_W = $clog2(REFILL_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(REFILL_DEPTH - 1);

    refill_beat_t mem [REFILL_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // credits keep the sender from overrunning, so no full check
    assign do_push    = refill_in.valid;
    assign do_pop     = beat_pop && beat_avail;
    assign beat_avail = (count != '0);

    always_comb
    begin
        beat_out       = mem[rd_ptr];
        beat_out.valid = beat_avail;
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= refill_in;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (!do_push && do_pop)
                count <= count - 1'b1;
        end
    end

    // one credit back per beat consumed
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            credit_return <= 1'b0;
        else
            credit_return <= do_pop;
    end

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/10ps

module icache_top
    import cache_pkg::*;
    import l2_pkg::*;
#(
    parameter int REFILL_DEPTH = 4
)
(
    input  logic         clk,
    input  logic         nrst,
    input  fetch_req_t   fetch_req,
    input  logic         flush,
    output logic         stall,
    output fetch_rsp_t   fetch_rsp,
    output l2_req_t      l2_req,
    input  refill_beat_t refill_in,
    output logic         credit_return
);

    refill_beat_t       beat_out;
    logic               beat_avail;
    logic               beat_pop;
    logic               rsp_valid;
    logic [DATA_W-1:0]  read_data;

    logic               rd_way;
    logic [INDEX_W-1:0] rd_index;
    logic [WORD_W-1:0]  rd_word;
    logic               wr_en;
    logic               wr_way;
    logic [INDEX_W-1:0] wr_index;
    logic [WORD_W-1:0]  wr_word;
    logic [DATA_W-1:0]  wr_data;

    icache_ctrl icache_ctrl_inst (
        .clk             (clk),
        .nrst            (nrst),
        .fetch_req       (fetch_req),
        .flush           (flush),
        .stall           (stall),
        .fetch_rsp_valid (rsp_valid),
        .l2_req          (l2_req),
        .beat_out        (beat_out),
        .beat_avail      (beat_avail),
        .beat_pop        (beat_pop),
        .rd_way          (rd_way),
        .rd_index        (rd_index),
        .rd_word         (rd_word),
        .wr_en           (wr_en),
        .wr_way          (wr_way),
        .wr_index        (wr_index),
        .wr_word         (wr_word),
        .wr_data         (wr_data)
    );

    icache_data_array icache_data_array_inst (
        .clk       (clk),
        .nrst      (nrst),
        .rd_way    (rd_way),
        .rd_index  (rd_index),
        .rd_word   (rd_word),
        .read_data (read_data),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_index  (wr_index),
        .wr_word   (wr_word),
        .wr_data   (wr_data)
    );

    refill_buffer #(
        .REFILL_DEPTH (REFILL_DEPTH)
    ) refill_buffer_inst (
        .clk           (clk),
        .nrst          (nrst),
        .refill_in     (refill_in),
        .beat_out      (beat_out),
        .beat_avail    (beat_avail),
        .beat_pop      (beat_pop),
        .credit_return (credit_return)
    );

    // data array output is already aligned with the valid pulse
    assign fetch_rsp = '{valid: rsp_valid, data: read_data};

endmodule

// File: dv/l2_model.sv
`timescale 1ns/10ps

module l2_model
    import l2_pkg::*;
#(
    parameter int          REFILL_DEPTH = 4,
    parameter logic [31:0] DATA_XOR     = 32'h0
)
(
    input  logic         clk,
    input  logic         nrst,
    input  l2_req_t      l2_req,
    input  logic [2:0]   gap_len,
    input  logic         credit_return,
    output refill_beat_t refill_in
);

    int                   credits;
    logic                 busy;
    logic [L2_ADDR_W-1:0] line_q;
    logic [1:0]           word_q;
    logic [2:0]           wait_q;   // idle cycles before the next beat
    logic                 send;

    assign send = busy && !l2_req.valid && (wait_q == 3'd0) && (credits > 0);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            credits   <= REFILL_DEPTH;
            busy      <= 1'b0;
            line_q    <= '0;
            word_q    <= '0;
            wait_q    <= '0;
            refill_in <= '0;
        end
        else
        begin
            credits   <= credits - int'(send) + int'(credit_return);
            refill_in <= '0;
            if (l2_req.valid)
            begin
                busy   <= 1'b1;
                line_q <= l2_req.line_addr;
                word_q <= 2'd0;
                wait_q <= gap_len;
            end
            else if (send)
            begin
                // byte address of the word, xor pattern
                refill_in <= '{valid: 1'b1,
                               data:  {line_q, word_q, 2'b00} ^ DATA_XOR,
                               last:  (word_q == 2'd3)};
                word_q    <= word_q + 2'd1;
                wait_q    <= gap_len;
                busy      <= (word_q != 2'd3);
            end
            else if (busy && (wait_q != 3'd0))
                wait_q <= wait_q - 3'd1;
        end
    end

endmodule

// File: dv/tb_icache.sv
`timescale 1ns/10ps

module tb_icache
    import cache_pkg::*;
    import l2_pkg::*;
();

    localparam int          REFILL_DEPTH = 4;
    localparam logic [31:0] LFSR_SEED    = 32'hc04ebe72;
    localparam logic [31:0] DATA_XOR     = 32'ha5a50000;
    localparam int          NUM_TESTS    = 6;
    localparam int          MAX_FETCHES  = 12;   // most fetches in one test
    localparam int          FETCH_BUDGET = 64;   // worst case miss in cycles
    localparam int          HIT_EDGES    = 3;    // rsp seen on the third edge after acceptance
    localparam real         WATCHDOG_NS  = (16.0 + NUM_TESTS * MAX_FETCHES * FETCH_BUDGET) * 8.0;
    localparam int          HIT = 0;
    localparam int          MISS = 1;
    localparam int          ANY = 2;

    logic         clk = 1'b0;
    logic         nrst;
    fetch_req_t   fetch_req;
    logic         flush;
    logic         stall;
    fetch_rsp_t   fetch_rsp;
    l2_req_t      l2_req;
    refill_beat_t refill_in;
    logic         credit_return;
    logic [2:0]   gap_len;

    logic [31:0] lfsr_q = LFSR_SEED;
    int          errors = 0;
    int          errs_before;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          beats_out;            // sent by l2, credit not yet back
    string       test_name;

    always #4 clk = ~clk;

    icache_top #(.REFILL_DEPTH (REFILL_DEPTH)) icache_top_inst (
        .clk           (clk),
        .nrst          (nrst),
        .fetch_req     (fetch_req),
        .flush         (flush),
        .stall         (stall),
        .fetch_rsp     (fetch_rsp),
        .l2_req        (l2_req),
        .refill_in     (refill_in),
        .credit_return (credit_return)
    );

    l2_model #(.REFILL_DEPTH (REFILL_DEPTH), .DATA_XOR (DATA_XOR)) l2_model_inst (
        .clk           (clk),
        .nrst          (nrst),
        .l2_req        (l2_req),
        .gap_len       (gap_len),
        .credit_return (credit_return),
        .refill_in     (refill_in)
    );

    always @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            beats_out <= 0;
        else
            beats_out <= beats_out + int'(refill_in.valid) - int'(credit_return);
    end

    assert property (@(posedge clk) disable iff (!nrst) beats_out <= REFILL_DEPTH)
    else
    begin
        errors++;
        $display("more than %0d refill beats outstanding at l2", REFILL_DEPTH);
    end

    assert property (@(posedge clk) disable iff (!nrst) credit_return |-> beats_out > 0)
    else
    begin
        errors++;
        $display("credit returned with no beat outstanding");
    end

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index);
        return {tag, index, 2'(take_bits(2)), 2'b00};   // random word in the line
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ DATA_XOR;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        errs_before = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errs_before)
            $display("test %0d %s: pass", tests_run, test_name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: fail with %0d errors", tests_run, test_name,
                     errors - errs_before);
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // one fetch, from request to response, with a cycle budget
    task automatic fetch(input logic [31:0] addr, input int kind);
        int   cycles;
        int   acc_at;
        int   reqs;
        logic done;
        cycles = 0;
        acc_at = -1;
        reqs   = 0;
        done   = 1'b0;
        @(posedge clk);
        fetch_req <= '{valid: 1'b1, addr: addr};
        while (!done && cycles < FETCH_BUDGET)
        begin
            @(posedge clk);
            gap_len <= 3'(take_bits(3));
            cycles++;
            if (acc_at < 0)
            begin
                if (fetch_req.valid && !stall)
                begin
                    acc_at = cycles;
                    fetch_req <= '0;
                end
            end
            else
            begin
                if (l2_req.valid)
                begin
                    reqs++;
                    check_value("l2_req.line_addr", {4'h0, addr[31:4]}, {4'h0, l2_req.line_addr});
                end
                done = fetch_rsp.valid;
            end
        end
        if (!done)
        begin
            fetch_req <= '0;
            check_true(1'b0, $sformatf("fetch of address %08h got no response in %0d cycles",
                                       addr, FETCH_BUDGET));
        end
        else
        begin
            check_value("fetch_rsp.data", expected_word(addr), fetch_rsp.data);
            if (kind == HIT)
            begin
                check_value("l2_req count", 0, reqs);
                check_value("hit response edge", HIT_EDGES, cycles - acc_at);
            end
            else if (kind == MISS)
                check_value("l2_req count", 1, reqs);
            else
                check_true(reqs <= 1, "more than one l2 request for a single fetch");
        end
    endtask

    initial
    begin
        logic [31:0] line_a;
        logic [31:0] line_b;
        logic [31:0] line_c;
        nrst      = 1'b0;
        fetch_req = '0;
        flush     = 1'b0;
        gap_len   = 3'd0;
        repeat (16) @(posedge clk);
        nrst <= 1'b1;

        begin_test("reset");
        @(posedge clk);
        check_value("stall", 0, 32'(stall));
        check_value("fetch_rsp.valid", 0, 32'(fetch_rsp.valid));
        check_value("l2_req.valid", 0, 32'(l2_req.valid));
        check_value("credit_return", 0, 32'(credit_return));
        finish_test();

        begin_test("cold miss");
        fetch(make_addr(23'h1, 5'd3), MISS);
        finish_test();

        begin_test("hit");
        repeat (3) fetch(make_addr(23'h1, 5'd3), HIT);
        finish_test();

        // a b a c leaves b as lru, so c evicts b
        begin_test("lru replacement");
        line_a = make_addr(23'h10, 5'd9);
        line_b = make_addr(23'h20, 5'd9);
        line_c = make_addr(23'h30, 5'd9);
        fetch(line_a, MISS);
        fetch(line_b, MISS);
        fetch(line_a, HIT);
        fetch(line_c, MISS);
        fetch(line_a, HIT);
        fetch(line_b, MISS);
        finish_test();

        begin_test("flush");
        fetch(make_addr(23'h1, 5'd3), HIT);
        pulse_flush();
        fetch(make_addr(23'h1, 5'd3), MISS);
        fetch(make_addr(23'h1, 5'd3), HIT);
        finish_test();

        begin_test("random gaps");
        for (int i = 0; i < MAX_FETCHES; i++)
            fetch(make_addr(23'h100 | 23'(take_bits(2)), 5'(take_bits(3))), ANY);
        finish_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the run did not complete");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: tb.f
hdl/cache_pkg.sv
hdl/l2_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_data_array.sv
hdl/refill_buffer.sv
hdl/icache_top.sv
dv/l2_model.sv
dv/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - hdl/cache_pkg.sv
      - hdl/l2_pkg.sv
      - hdl/icache_ctrl.sv
      - hdl/icache_data_array.sv
      - hdl/refill_buffer.sv
      - hdl/icache_top.sv
  - target: test
    files:
      - dv/l2_model.sv
      - dv/tb_icache.sv
